//--- csr_subsys.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_cmd_decode.sv
rtl/irq_sync.sv
rtl/csr_file.sv
rtl/irq_arbiter.sv
rtl/csr_unit_top.sv
test/csr_unit_properties.sv
test/tb_csr_unit.sv

//--- rtl/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Identification words returned by the read-only CSRs
`define CSR_MARCHID 32'h0000_0018
`define CSR_MIMPID 32'h0000_0006

// MXL = 1 (32-bit), extension I only
`define CSR_MISA 32'h4000_0100

// Platform fast interrupt lines, mapped to mip/mie bits 31:16
`define CSR_FAST_IRQS 16

// Flops per line in the interrupt synchronizer
`define CSR_SYNC_STAGES 2

`endif

//--- rtl/csr_cmd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module csr_cmd_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 csr_req,
    input  logic [2:0]           csr_func3,
    input  logic [4:0]           csr_imm,
    input  logic [11:0]          csr_addr,
    input  logic [31:0]          csr_wdata,
    output logic                 cmd_valid,
    output csr_pkg::csr_op_t     cmd_op,
    output csr_pkg::csr_addr_t   cmd_addr,
    output logic [31:0]          cmd_operand
);

    logic [31:0]        operand_sel;
    csr_pkg::csr_op_t   op_sel;

    // func3[2] picks the zero-extended uimm field instead of rs1
    assign operand_sel = csr_func3[2] ? {27'b0, csr_imm} : csr_wdata;
    assign op_sel = csr_pkg::csr_op_t'(csr_func3[1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= csr_req; // One request per pulse
        end
    end

    // Command payload, loaded only with a request
    always_ff @(posedge clk) begin
        if (csr_req) begin
            cmd_op      <= op_sel;
            cmd_addr    <= csr_pkg::csr_addr_t'(csr_addr); // Unlisted values pass through
            cmd_operand <= operand_sel;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module csr_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmd_valid,
    input  csr_pkg::csr_op_t              cmd_op,
    input  csr_pkg::csr_addr_t            cmd_addr,
    input  logic [31:0]                   cmd_operand,
    input  logic                          instret,
    input  logic [63:0]                   time_in,
    input  logic [`CSR_FAST_IRQS+2:0]     sync_irq,
    output logic [31:0]                   csr_rdata,
    output logic                          csr_rvalid,
    output logic [31:0]                   pend_mask,
    output logic                          global_ie
);

    // Writable bits of mie: fast lines, MEIE, MTIE, MSIE
    localparam logic [31:0] MIE_MASK   = 32'hffff_0888;
    localparam logic [31:0] MTVEC_MASK = 32'hffff_fffd; // Bit 1 reserved
    localparam logic [31:0] MEPC_MASK  = 32'hffff_fffc;

    logic        mstatus_mie;
    logic        mstatus_mpie;
    logic [31:0] mie_q;
    logic [31:0] mip_q;
    logic [31:0] mtvec_q;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;
    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;

    logic [31:0] mstatus_rd;
    logic [31:0] old_val;
    logic [31:0] new_val;
    logic        wr_en;

    // MPP is hardwired to M-mode
    assign mstatus_rd = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};

    always_comb begin
        case (cmd_addr)
            csr_pkg::ADDR_MSTATUS:   old_val = mstatus_rd;
            csr_pkg::ADDR_MISA:      old_val = `CSR_MISA;
            csr_pkg::ADDR_MIE:       old_val = mie_q;
            csr_pkg::ADDR_MTVEC:     old_val = mtvec_q;
            csr_pkg::ADDR_MSCRATCH:  old_val = mscratch_q;
            csr_pkg::ADDR_MEPC:      old_val = mepc_q;
            csr_pkg::ADDR_MCAUSE:    old_val = mcause_q;
            csr_pkg::ADDR_MTVAL:     old_val = mtval_q;
            csr_pkg::ADDR_MIP:       old_val = mip_q;
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE:     old_val = mcycle_q[31:0];
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLEH:    old_val = mcycle_q[63:32];
            csr_pkg::ADDR_MINSTRET,
            csr_pkg::ADDR_INSTRET:   old_val = minstret_q[31:0];
            csr_pkg::ADDR_MINSTRETH,
            csr_pkg::ADDR_INSTRETH:  old_val = minstret_q[63:32];
            csr_pkg::ADDR_TIME:      old_val = time_in[31:0];
            csr_pkg::ADDR_TIMEH:     old_val = time_in[63:32];
            csr_pkg::ADDR_MARCHID:   old_val = `CSR_MARCHID;
            csr_pkg::ADDR_MIMPID:    old_val = `CSR_MIMPID;
            default:                 old_val = 32'b0; // mstatush and unknown addresses
        endcase
    end

    // Read-modify-write value
    always_comb begin
        case (cmd_op)
            csr_pkg::CSR_OP_WRITE: new_val = cmd_operand;
            csr_pkg::CSR_OP_SET:   new_val = old_val | cmd_operand;
            csr_pkg::CSR_OP_CLEAR: new_val = old_val & ~cmd_operand;
            default:               new_val = old_val;
        endcase
    end

    assign wr_en = cmd_valid && (cmd_op != csr_pkg::CSR_OP_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b1;
            mie_q        <= '0;
            mtvec_q      <= '0;
            mscratch_q   <= '0;
            mepc_q       <= '0;
            mcause_q     <= '0;
            mtval_q      <= '0;
        end else if (wr_en) begin
            case (cmd_addr)
                csr_pkg::ADDR_MSTATUS: begin
                    mstatus_mie  <= new_val[3];
                    mstatus_mpie <= new_val[7];
                end
                csr_pkg::ADDR_MIE:      mie_q      <= new_val & MIE_MASK;
                csr_pkg::ADDR_MTVEC:    mtvec_q    <= new_val & MTVEC_MASK;
                csr_pkg::ADDR_MSCRATCH: mscratch_q <= new_val;
                csr_pkg::ADDR_MEPC:     mepc_q     <= new_val & MEPC_MASK;
                csr_pkg::ADDR_MCAUSE:   mcause_q   <= new_val;
                csr_pkg::ADDR_MTVAL:    mtval_q    <= new_val;
                default: ;              // Read-only or unknown
            endcase
        end
    end

    // A written half replaces the count for this cycle, no increment
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_q <= '0;
        end else if (wr_en && cmd_addr == csr_pkg::ADDR_MCYCLE) begin
            mcycle_q <= {mcycle_q[63:32], new_val};
        end else if (wr_en && cmd_addr == csr_pkg::ADDR_MCYCLEH) begin
            mcycle_q <= {new_val, mcycle_q[31:0]};
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            minstret_q <= '0;
        end else if (wr_en && cmd_addr == csr_pkg::ADDR_MINSTRET) begin
            minstret_q <= {minstret_q[63:32], new_val};
        end else if (wr_en && cmd_addr == csr_pkg::ADDR_MINSTRETH) begin
            minstret_q <= {new_val, minstret_q[31:0]};
        end else if (instret) begin
            minstret_q <= minstret_q + 64'd1; // Retired instruction
        end
    end

    // Line order from the synchronizer is {fast, external, timer, software}
    always_ff @(posedge clk) begin
        if (reset) begin
            mip_q <= '0;
        end else begin
            mip_q <= {sync_irq[`CSR_FAST_IRQS+2:3], 4'b0, sync_irq[2], 3'b0,
                      sync_irq[1], 3'b0, sync_irq[0], 3'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_rvalid <= 1'b0;
        end else begin
            csr_rvalid <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            csr_rdata <= old_val; // Value before the write
        end
    end

    assign pend_mask = mip_q & mie_q;
    assign global_ie = mstatus_mie;

endmodule

`default_nettype wire

//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // func3[1:0] of a CSR instruction
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_t;

    typedef enum logic [11:0] {
        ADDR_MSTATUS   = 12'h300,
        ADDR_MISA      = 12'h301,
        ADDR_MIE       = 12'h304,
        ADDR_MTVEC     = 12'h305,
        ADDR_MSTATUSH  = 12'h310,
        ADDR_MSCRATCH  = 12'h340,
        ADDR_MEPC      = 12'h341,
        ADDR_MCAUSE    = 12'h342,
        ADDR_MTVAL     = 12'h343,
        ADDR_MIP       = 12'h344,
        ADDR_MCYCLE    = 12'hB00,
        ADDR_MINSTRET  = 12'hB02,
        ADDR_MCYCLEH   = 12'hB80,
        ADDR_MINSTRETH = 12'hB82,
        ADDR_CYCLE     = 12'hC00,
        ADDR_TIME      = 12'hC01,
        ADDR_INSTRET   = 12'hC02,
        ADDR_CYCLEH    = 12'hC80,
        ADDR_TIMEH     = 12'hC81,
        ADDR_INSTRETH  = 12'hC82,
        ADDR_MARCHID   = 12'hF12,
        ADDR_MIMPID    = 12'hF13
    } csr_addr_t;

    // Exception codes of the interrupt causes, fast line i is 16 + i
    typedef enum logic [4:0] {
        IRQ_CAUSE_NONE     = 5'd0,
        IRQ_CAUSE_SOFTWARE = 5'd3,
        IRQ_CAUSE_TIMER    = 5'd7,
        IRQ_CAUSE_EXTERNAL = 5'd11,
        IRQ_CAUSE_FAST[16] = 5'd16
    } irq_cause_t;

endpackage

`default_nettype wire

//--- rtl/csr_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module csr_unit_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       csr_req,
    input  logic [2:0]                 csr_func3,
    input  logic [4:0]                 csr_imm,
    input  logic [11:0]                csr_addr,
    input  logic [31:0]                csr_wdata,
    output logic [31:0]                csr_rdata,
    output logic                       csr_rvalid,
    input  logic                       instret,
    input  logic [63:0]                time_in,
    input  logic                       irq_external,
    input  logic                       irq_timer,
    input  logic                       irq_software,
    input  logic [`CSR_FAST_IRQS-1:0]  irq_fast,
    output logic                       irq_req,
    output csr_pkg::irq_cause_t        irq_cause
);

    logic                         cmd_valid;
    csr_pkg::csr_op_t             cmd_op;
    csr_pkg::csr_addr_t           cmd_addr;
    logic [31:0]                  cmd_operand;
    logic [`CSR_FAST_IRQS+2:0]    sync_irq;
    logic [31:0]                  pend_mask;
    logic                         global_ie;

    csr_cmd_decode u_csr_cmd_decode (
        .clk         (clk),
        .reset       (reset),
        .csr_req     (csr_req),
        .csr_func3   (csr_func3),
        .csr_imm     (csr_imm),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_operand (cmd_operand)
    );

    // Software line lands in bit 0
    irq_sync #(
        .WIDTH  (`CSR_FAST_IRQS + 3),
        .STAGES (`CSR_SYNC_STAGES)
    ) u_irq_sync (
        .clk      (clk),
        .reset    (reset),
        .async_in ({irq_fast, irq_external, irq_timer, irq_software}),
        .sync_out (sync_irq)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_operand (cmd_operand),
        .instret     (instret),
        .time_in     (time_in),
        .sync_irq    (sync_irq),
        .csr_rdata   (csr_rdata),
        .csr_rvalid  (csr_rvalid),
        .pend_mask   (pend_mask),
        .global_ie   (global_ie)
    );

    irq_arbiter u_irq_arbiter (
        .clk       (clk),
        .reset     (reset),
        .pend_mask (pend_mask),
        .global_ie (global_ie),
        .irq_req   (irq_req),
        .irq_cause (irq_cause)
    );

endmodule

`default_nettype wire

//--- rtl/irq_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module irq_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           pend_mask,
    input  logic                  global_ie,
    output logic                  irq_req,
    output csr_pkg::irq_cause_t   irq_cause
);

    logic                  req_next;
    csr_pkg::irq_cause_t   cause_next;

    // Fixed order: external, software, timer, then fast lines
    always_comb begin
        req_next   = 1'b0;
        cause_next = csr_pkg::IRQ_CAUSE_NONE;
        if (global_ie) begin
            if (pend_mask[11]) begin
                req_next   = 1'b1;
                cause_next = csr_pkg::IRQ_CAUSE_EXTERNAL;
            end else if (pend_mask[3]) begin
                req_next   = 1'b1;
                cause_next = csr_pkg::IRQ_CAUSE_SOFTWARE;
            end else if (pend_mask[7]) begin
                req_next   = 1'b1;
                cause_next = csr_pkg::IRQ_CAUSE_TIMER;
            end else begin
                // Scan downward so the lowest pending index wins
                for (int i = `CSR_FAST_IRQS - 1; i >= 0; i--) begin
                    if (pend_mask[16 + i]) begin
                        req_next   = 1'b1;
                        cause_next = csr_pkg::irq_cause_t'(5'(16 + i));
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq_req   <= 1'b0;
            irq_cause <= csr_pkg::IRQ_CAUSE_NONE;
        end else begin
            irq_req   <= req_next;
            irq_cause <= cause_next; // Zero when nothing is taken
        end
    end

endmodule

`default_nettype wire

//--- rtl/irq_sync.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module irq_sync #(
    parameter int WIDTH  = `CSR_FAST_IRQS + 3,
    parameter int STAGES = `CSR_SYNC_STAGES
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] async_in,
    output logic [WIDTH-1:0] sync_out
);

    // Stage 0 takes the raw lines, the last stage is the clean output
    logic [STAGES-1:0][WIDTH-1:0] chain;

    always_ff @(posedge clk) begin
        if (reset) begin
            chain <= '0;
        end else begin
            chain[0] <= async_in;
            for (int s = 1; s < STAGES; s++) begin
                chain[s] <= chain[s-1];
            end
        end
    end

    assign sync_out = chain[STAGES-1];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f csr_subsys.f --top-module tb_csr_unit

sim_out=$(./obj_dir/Vtb_csr_unit)
echo "$sim_out"

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

//--- test/csr_unit_properties.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_properties (
    input wire logic clk,
    input wire logic reset,
    input wire logic csr_req,
    input wire logic csr_rvalid,
    input wire logic irq_req,
    input wire logic global_ie
);

    // Decode stage plus file stage
    rvalid_latency: assert property (
        @(posedge clk) disable iff (reset)
        csr_rvalid == $past(csr_req, 2)
    ) else $error("csr_rvalid does not follow csr_req by two cycles");

    // Arbiter registers one edge after mstatus.MIE
    irq_needs_mie: assert property (
        @(posedge clk) disable iff (reset)
        !$past(global_ie) |-> !irq_req
    ) else $error("irq_req high while mstatus.MIE was low");

    outputs_after_reset: assert property (
        @(posedge clk)
        reset |=> (!csr_rvalid && !irq_req)
    ) else $error("csr_rvalid or irq_req high after reset");

endmodule

bind csr_unit_top csr_unit_properties u_csr_unit_properties (
    .clk        (clk),
    .reset      (reset),
    .csr_req    (csr_req),
    .csr_rvalid (csr_rvalid),
    .irq_req    (irq_req),
    .global_ie  (global_ie)
);

`default_nettype wire

//--- test/tb_csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_cfg.svh"

module tb_csr_unit;

    localparam int RMW_CMDS = 300;
    localparam int IMM_CMDS = 20;
    localparam int IRQ_ROUNDS = 12;
    localparam int LIMIT = RMW_CMDS + 4 * IMM_CMDS + 40 + 100 + IRQ_ROUNDS * 30 + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        csr_req;
    logic [2:0]  csr_func3;
    logic [4:0]  csr_imm;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic        csr_rvalid;
    logic        instret;
    logic [63:0] time_in;
    logic        irq_external;
    logic        irq_timer;
    logic        irq_software;
    logic [15:0] irq_fast;
    logic        irq_req;
    csr_pkg::irq_cause_t irq_cause;

    logic [31:0] lfsr = 32'hf6f0462c;
    logic [31:0] model [7];   // mstatus, mie, mtvec, mscratch, mepc, mcause, mtval
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];
    string       name_q [$];
    bit          chk_q [$];
    int          errors = 0;
    int          read_errors = 0;
    int          cycles = 0;
    logic [31:0] mon_exp;
    string       mon_name;
    bit          mon_chk;

    csr_unit_top u_csr_unit_top (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Returned reads are checked against the queue in order
    always @(negedge clk) begin
        if (!reset && csr_rvalid) begin
            if (exp_q.size() == 0) begin
                $display("Read data returned with no request outstanding");
                read_errors++;
            end else begin
                mon_exp = exp_q.pop_front();
                mon_name = name_q.pop_front();
                mon_chk = chk_q.pop_front();
                if (mon_chk) begin
                    if (csr_rdata !== mon_exp) begin
                        $display("ERR %s expected %h actual %h", mon_name, mon_exp, csr_rdata);
                        read_errors++;
                    end
                end else begin
                    got_q.push_back(csr_rdata);
                end
            end
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [11:0] idx_addr(input int idx);
        case (idx)
            0: return 12'h300;
            1: return 12'h304;
            2: return 12'h305;
            3: return 12'h340;
            4: return 12'h341;
            5: return 12'h342;
            default: return 12'h343;
        endcase
    endfunction

    function automatic logic [31:0] wr_mask(input int idx);
        case (idx)
            0: return 32'h0000_0088;
            1: return 32'hffff_0888;
            2: return 32'hffff_fffd;
            4: return 32'hffff_fffc;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // Returns the old value and applies the operation to the model
    function automatic logic [31:0] model_rmw(input int idx, input logic [1:0] op,
                                              input logic [31:0] operand);
        logic [31:0] old;
        logic [31:0] nv;
        old = model[idx] | ((idx == 0) ? 32'h0000_1800 : 32'h0); // MPP reads 3
        case (op)
            2'b01: nv = operand;
            2'b10: nv = old | operand;
            2'b11: nv = old & ~operand;
            default: nv = old;
        endcase
        if (op != 2'b00) begin
            model[idx] = nv & wr_mask(idx);
        end
        return old;
    endfunction

    function automatic logic [4:0] expected_cause(input logic [31:0] pend);
        if (pend[11]) return 5'd11;
        if (pend[3]) return 5'd3;
        if (pend[7]) return 5'd7;
        for (int i = 0; i < 16; i++) begin
            if (pend[16 + i]) return 5'(16 + i);
        end
        return 5'd0;
    endfunction

    task automatic send(input logic [2:0] f3, input logic [11:0] a, input logic [4:0] imm,
                        input logic [31:0] wd, input logic [31:0] exp, input bit chk,
                        input string name);
        exp_q.push_back(exp);
        chk_q.push_back(chk);
        name_q.push_back(name);
        csr_req = 1'b1;
        csr_func3 = f3;
        csr_addr = a;
        csr_imm = imm;
        csr_wdata = wd;
        @(posedge clk);
        #1;
        csr_req = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        #1;
    endtask

    // Model-tracked command to a writable register
    task automatic rmw(input int idx, input logic [1:0] op, input bit use_imm,
                       input logic [4:0] imm, input logic [31:0] wd, input string name);
        logic [31:0] operand;
        logic [31:0] old;
        operand = use_imm ? {27'b0, imm} : wd;
        old = model_rmw(idx, op, operand);
        send({use_imm, op}, idx_addr(idx), imm, wd, old, 1'b1, name);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] w;
        logic [31:0] mip_exp;
        logic [11:0] unk [3];
        int          idx;
        int          k;
        int          cnt;

        reset = 1'b1;
        csr_req = 1'b0;
        csr_func3 = '0;
        csr_imm = '0;
        csr_addr = '0;
        csr_wdata = '0;
        instret = 1'b0;
        time_in = '0;
        irq_external = 1'b0;
        irq_timer = 1'b0;
        irq_software = 1'b0;
        irq_fast = '0;
        for (int i = 0; i < 7; i++) model[i] = '0;
        model[0] = 32'h0000_0080; // MPIE after reset
        unk[0] = 12'h7c0;
        unk[1] = 12'h345;
        unk[2] = 12'h310;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        idx = 0;
        for (int n = 0; n < RMW_CMDS; n++) begin
            r = rand_bits(2);
            if (r[1:0] != 2'b00) begin // Otherwise repeat the last address
                r = rand_bits(3);
                idx = r % 7;
            end
            a = rand_bits(2);
            b = rand_bits(6);
            rmw(idx, a[1:0], b[5], b[4:0], rand_bits(32), "rmw");
        end
        drain();

        for (int n = 0; n < IMM_CMDS; n++) begin
            r = rand_bits(3);
            idx = r % 7;
            a = rand_bits(2);
            b = rand_bits(5);
            rmw(idx, a[1:0], 1'b1, b[4:0], 32'h0, "imm_op");
            rmw(idx, 2'b10, 1'b0, 5'd0, 32'h0, "imm_readback");
        end
        drain();

        send(3'b001, 12'h301, 5'd0, rand_bits(32), `CSR_MISA, 1'b1, "misa");
        send(3'b010, 12'h301, 5'd0, 32'h0, `CSR_MISA, 1'b1, "misa_read");
        send(3'b011, 12'hf12, 5'd0, rand_bits(32), `CSR_MARCHID, 1'b1, "marchid");
        send(3'b010, 12'hf12, 5'd0, 32'h0, `CSR_MARCHID, 1'b1, "marchid_read");
        send(3'b101, 12'hf13, 5'd31, 32'h0, `CSR_MIMPID, 1'b1, "mimpid");
        send(3'b010, 12'hf13, 5'd0, 32'h0, `CSR_MIMPID, 1'b1, "mimpid_read");
        send(3'b001, 12'h344, 5'd0, 32'hffff_ffff, 32'h0, 1'b1, "mip_write");
        send(3'b010, 12'h344, 5'd0, 32'h0, 32'h0, 1'b1, "mip_read");
        for (int i = 0; i < 3; i++) begin
            send(3'b001, unk[i], 5'd0, rand_bits(32), 32'h0, 1'b1, "unknown");
            send(3'b010, unk[i], 5'd0, 32'h0, 32'h0, 1'b1, "unknown_read");
        end
        drain();

        // mcycle reads k cycles apart, none op so the counter keeps running
        r = rand_bits(3);
        k = 2 + int'(r);
        send(3'b000, 12'hb00, 5'd0, 32'h0, 32'h0, 1'b0, "");
        idle(k - 1);
        send(3'b000, 12'hb00, 5'd0, 32'h0, 32'h0, 1'b0, "");
        drain();
        a = got_q.pop_front();
        b = got_q.pop_front();
        if (b - a != k) begin
            $display("ERR mcycle_delta expected %h actual %h", k, b - a);
            errors++;
        end

        // mcycle write, then read j cycles later
        w = rand_bits(32);
        r = rand_bits(3);
        k = 2 + int'(r);
        send(3'b001, 12'hb00, 5'd0, w, 32'h0, 1'b0, "");
        idle(k - 1);
        send(3'b010, 12'hb00, 5'd0, 32'h0, 32'h0, 1'b0, "");
        drain();
        a = got_q.pop_front();
        b = got_q.pop_front();
        if (b != w + k - 1) begin
            $display("ERR mcycle_write expected %h actual %h", w + k - 1, b);
            errors++;
        end

        // minstret counts instret pulses between two reads
        cnt = 0;
        send(3'b000, 12'hb02, 5'd0, 32'h0, 32'h0, 1'b0, "");
        for (int n = 0; n < 12; n++) begin
            r = rand_bits(1);
            instret = r[0];
            if (r[0]) cnt++;
            @(posedge clk);
            #1;
        end
        instret = 1'b0;
        send(3'b010, 12'hc02, 5'd0, 32'h0, 32'h0, 1'b0, "");
        drain();
        a = got_q.pop_front();
        b = got_q.pop_front();
        if (b - a != cnt) begin
            $display("ERR minstret_delta expected %h actual %h", cnt, b - a);
            errors++;
        end

        time_in = {rand_bits(32), rand_bits(32)};
        send(3'b010, 12'hc01, 5'd0, 32'h0, time_in[31:0], 1'b1, "time");
        send(3'b010, 12'hc81, 5'd0, 32'h0, time_in[63:32], 1'b1, "timeh");
        drain();

        for (int n = 0; n < IRQ_ROUNDS; n++) begin
            r = rand_bits(19);
            irq_software = r[0];
            irq_timer = r[1];
            irq_external = r[2];
            irq_fast = r[18:3];
            mip_exp = {irq_fast, 4'b0, irq_external, 3'b0, irq_timer, 3'b0,
                       irq_software, 3'b0};
            idle(8);
            send(3'b010, 12'h344, 5'd0, 32'h0, mip_exp, 1'b1, "mip_lines");
            rmw(1, 2'b01, 1'b0, 5'd0, rand_bits(32), "mie_write");
            rmw(0, 2'b10, 1'b0, 5'd0, 32'h8, "mie_enable");
            drain();
            idle(2);
            if (irq_req != ((mip_exp & model[1]) != 0)) begin
                $display("ERR irq_req expected %h actual %h",
                         (mip_exp & model[1]) != 0, irq_req);
                errors++;
            end
            if (irq_cause != expected_cause(mip_exp & model[1])) begin
                $display("ERR irq_cause expected %h actual %h",
                         expected_cause(mip_exp & model[1]), irq_cause);
                errors++;
            end
            rmw(0, 2'b11, 1'b0, 5'd0, 32'h8, "mie_disable");
            drain();
            idle(2);
            if (irq_req != 1'b0) begin
                $display("ERR irq_masked expected %h actual %h", 1'b0, irq_req);
                errors++;
            end
        end

        idle(2);
        $display("Errors: checks %0d, reads %0d", errors, read_errors);
        if (errors == 0 && read_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
